/* logic/rv_pkg.sv */
////////////////////////////////////////
// rv32i width types, opcode and funct3
// constants, control and retire structs
////////////////////////////////////////
`default_nettype none

package rv_pkg;

	typedef logic [31:0] xlen_t; // one architectural word
	typedef logic [4:0] reg_addr_t; // x0 to x31
	typedef logic [2:0] funct3_t;
	typedef logic [2:0] alu_op_t; // same code as arith funct3
	typedef logic [6:0] opcode_t; // instr[6:0]

	// major opcodes
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;

	// alu ops, straight from funct3 of op/op-imm
	localparam alu_op_t ALU_ADD  = 3'b000; // sub with alu_sub
	localparam alu_op_t ALU_SLL  = 3'b001;
	localparam alu_op_t ALU_SLT  = 3'b010;
	localparam alu_op_t ALU_SLTU = 3'b011;
	localparam alu_op_t ALU_XOR  = 3'b100;
	localparam alu_op_t ALU_SR   = 3'b101; // srl, sra with alu_sub
	localparam alu_op_t ALU_OR   = 3'b110;
	localparam alu_op_t ALU_AND  = 3'b111;

	// load/store size
	localparam funct3_t F3_B  = 3'b000;
	localparam funct3_t F3_H  = 3'b001;
	localparam funct3_t F3_W  = 3'b010;
	localparam funct3_t F3_BU = 3'b100; // loads only
	localparam funct3_t F3_HU = 3'b101; // loads only

	// branch conditions
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	typedef struct packed {
		logic reg_write; // rd takes result
		logic alu_src_imm; // srcb from immediate
		logic mem_write;
		logic mem_to_reg; // load data to rd
		logic branch;
		logic jump; // jal
		logic jalr;
		logic lui;
		logic auipc;
		alu_op_t alu_op;
		logic alu_sub; // sub and sra
	} ctrl_t; // 13 bits

	// one register write per retired instruction
	typedef struct packed {
		logic valid;
		reg_addr_t rd;
		xlen_t data;
	} retire_t; // 38 bits

endpackage : rv_pkg

`default_nettype wire

/* logic/rv_alu.sv */
////////////////////////////////////////
// eight-op integer alu
////////////////////////////////////////
`default_nettype none

module rv_alu (
	input rv_pkg::xlen_t a,
	input rv_pkg::xlen_t b,
	input rv_pkg::alu_op_t op,
	input logic sub,
	output rv_pkg::xlen_t y
);

	logic [4:0] shamt;

	assign shamt = b[4:0]; // upper bits ignored

	always_comb begin
		case (op)
			rv_pkg::ALU_ADD: begin
				y = sub ? (a - b) : (a + b);
			end
			rv_pkg::ALU_SLL: y = a << shamt;
			rv_pkg::ALU_SLT: begin
				y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			end
			rv_pkg::ALU_SLTU: y = (a < b) ? 32'd1 : 32'd0;
			rv_pkg::ALU_XOR: y = a ^ b;
			rv_pkg::ALU_SR: begin
				// arithmetic shift keeps the sign bit
				if (sub) begin
					y = $signed(a) >>> shamt;
				end else begin
					y = a >> shamt;
				end
			end
			rv_pkg::ALU_OR: y = a | b;
			rv_pkg::ALU_AND: y = a & b;
			default: y = '0;
		endcase
	end

endmodule : rv_alu

`default_nettype wire

/* logic/rv_imm_decode.sv */
////////////////////////////////////////
// register fields and rv32i immediates
////////////////////////////////////////
`default_nettype none

module rv_imm_decode (
	input rv_pkg::xlen_t instr,
	output rv_pkg::reg_addr_t rs1,
	output rv_pkg::reg_addr_t rs2,
	output rv_pkg::reg_addr_t rd,
	output rv_pkg::funct3_t funct3,
	output rv_pkg::xlen_t imm_i,
	output rv_pkg::xlen_t imm_s,
	output rv_pkg::xlen_t imm_b,
	output rv_pkg::xlen_t imm_u,
	output rv_pkg::xlen_t imm_j
);

	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];
	assign funct3 = instr[14:12];

	// sign always from bit 31
	assign imm_i = {{20{instr[31]}}, instr[31:20]}; // op-imm, load, jalr
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
		instr[11:8], 1'b0}; // even offsets only
	assign imm_u = {instr[31:12], 12'b0}; // lui, auipc
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
		instr[30:21], 1'b0};

endmodule : rv_imm_decode

`default_nettype wire

/* logic/rv_regfile.sv */
////////////////////////////////////////
// 2r1w register file, x0 reads zero
////////////////////////////////////////
`default_nettype none

module rv_regfile (
	input logic clk,
	input logic we,
	input rv_pkg::reg_addr_t rs1,
	input rv_pkg::reg_addr_t rs2,
	input rv_pkg::reg_addr_t rd,
	input rv_pkg::xlen_t wd,
	output rv_pkg::xlen_t rs1_data,
	output rv_pkg::xlen_t rs2_data
);

	rv_pkg::xlen_t regs [1:31]; // no storage behind x0

	// write lands at the edge that ends the instruction
	always_ff @(posedge clk) begin
		if (we && (rd != '0)) begin
			regs[rd] <= wd;
		end
	end

	// combinational reads
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule : rv_regfile

`default_nettype wire

/* logic/rv_control.sv */
////////////////////////////////////////
// main decoder, opcode/funct to ctrl_t
////////////////////////////////////////
`default_nettype none

module rv_control (
	input rv_pkg::xlen_t instr,
	output rv_pkg::ctrl_t ctrl
);

	rv_pkg::opcode_t opcode;
	rv_pkg::funct3_t funct3;
	logic f7_alt; // funct7 bit 5 picks sub/sra

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign f7_alt = instr[30];

	always_comb begin
		// all zero is a nop and leaves alu_op at add
		ctrl = '0;
		case (opcode)
			rv_pkg::OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.lui = 1'b1;
			end
			rv_pkg::OP_AUIPC: begin
				ctrl.reg_write = 1'b1;
				ctrl.auipc = 1'b1;
			end
			rv_pkg::OP_JAL: begin
				ctrl.reg_write = 1'b1; // link
				ctrl.jump = 1'b1;
			end
			rv_pkg::OP_JALR: begin
				ctrl.reg_write = 1'b1;
				ctrl.jalr = 1'b1;
				ctrl.alu_src_imm = 1'b1; // target = rs1 + imm_i
			end
			rv_pkg::OP_BRANCH: begin
				ctrl.branch = 1'b1; // condition judged in datapath
			end
			rv_pkg::OP_LOAD: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			rv_pkg::OP_STORE: begin
				ctrl.alu_src_imm = 1'b1; // s-type imm for address
				ctrl.mem_write = 1'b1;
			end
			rv_pkg::OP_IMM: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op = funct3;
				// no subi, only srai uses bit 30
				ctrl.alu_sub = f7_alt && (funct3 == rv_pkg::ALU_SR);
			end
			rv_pkg::OP_REG: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = funct3;
				ctrl.alu_sub = f7_alt &&
					(funct3 == rv_pkg::ALU_ADD || funct3 == rv_pkg::ALU_SR);
			end
			default: begin
				ctrl = '0; // fence, system and unknown
			end
		endcase
	end

endmodule : rv_control

`default_nettype wire

/* logic/rv_datapath.sv */
////////////////////////////////////////
// pc, operand/result muxes, branch
// compare and retire report
////////////////////////////////////////
`default_nettype none

module rv_datapath (
	input logic clk,
	input logic reset,
	input rv_pkg::xlen_t instr,
	input rv_pkg::ctrl_t ctrl,
	output rv_pkg::xlen_t pc,
	output rv_pkg::xlen_t mem_addr,
	output rv_pkg::xlen_t mem_wdata,
	output rv_pkg::funct3_t mem_funct3,
	input rv_pkg::xlen_t mem_rdata,
	output rv_pkg::retire_t retire
);

	rv_pkg::reg_addr_t rs1;
	rv_pkg::reg_addr_t rs2;
	rv_pkg::reg_addr_t rd;
	rv_pkg::funct3_t funct3;
	rv_pkg::xlen_t imm_i;
	rv_pkg::xlen_t imm_s;
	rv_pkg::xlen_t imm_b;
	rv_pkg::xlen_t imm_u;
	rv_pkg::xlen_t imm_j;
	rv_pkg::xlen_t rs1_data;
	rv_pkg::xlen_t rs2_data;
	rv_pkg::xlen_t srcb;
	rv_pkg::xlen_t alu_y;
	rv_pkg::xlen_t pc_plus4;
	rv_pkg::xlen_t pc_next;
	rv_pkg::xlen_t result; // rd write data
	logic reg_we;
	logic cond; // branch condition holds
	logic br_taken;

	rv_imm_decode imm_decode_i (
		.instr(instr),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.funct3(funct3),
		.imm_i(imm_i),
		.imm_s(imm_s),
		.imm_b(imm_b),
		.imm_u(imm_u),
		.imm_j(imm_j)
	);

	assign reg_we = ctrl.reg_write && reset; // quiet while in reset

	rv_regfile regfile_i (
		.clk(clk),
		.we(reg_we),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.wd(result),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	// stores address with s-imm, everything else with i-imm
	always_comb begin
		if (!ctrl.alu_src_imm) begin
			srcb = rs2_data;
		end else if (ctrl.mem_write) begin
			srcb = imm_s;
		end else begin
			srcb = imm_i;
		end
	end

	rv_alu alu_i (
		.a(rs1_data),
		.b(srcb),
		.op(ctrl.alu_op),
		.sub(ctrl.alu_sub),
		.y(alu_y)
	);

	// branch compare on the raw register values
	always_comb begin
		case (funct3)
			rv_pkg::F3_BEQ: cond = (rs1_data == rs2_data);
			rv_pkg::F3_BNE: cond = (rs1_data != rs2_data);
			rv_pkg::F3_BLT: cond = ($signed(rs1_data) < $signed(rs2_data));
			rv_pkg::F3_BGE: cond = ($signed(rs1_data) >= $signed(rs2_data));
			rv_pkg::F3_BLTU: cond = (rs1_data < rs2_data);
			rv_pkg::F3_BGEU: cond = (rs1_data >= rs2_data);
			default: cond = 1'b0; // 010/011 reserved
		endcase
	end

	assign br_taken = ctrl.branch && cond;
	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		if (ctrl.jalr) begin
			pc_next = {alu_y[31:1], 1'b0}; // target lsb dropped
		end else if (ctrl.jump) begin
			pc_next = pc + imm_j;
		end else if (br_taken) begin
			pc_next = pc + imm_b;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= '0; // first fetch at 0
		end else begin
			pc <= pc_next;
		end
	end

	always_comb begin
		if (ctrl.jump || ctrl.jalr) begin
			result = pc_plus4; // link address
		end else if (ctrl.auipc) begin
			result = pc + imm_u;
		end else if (ctrl.lui) begin
			result = imm_u;
		end else if (ctrl.mem_to_reg) begin
			result = mem_rdata; // already extended
		end else begin
			result = alu_y;
		end
	end

	assign mem_addr = alu_y;
	assign mem_wdata = rs2_data;
	assign mem_funct3 = funct3;

	// x0 writes still reported
	assign retire.valid = reg_we;
	assign retire.rd = rd;
	assign retire.data = result;

endmodule : rv_datapath

`default_nettype wire

/* logic/rv_data_mem.sv */
////////////////////////////////////////
// data memory, sub-word stores and
// sign/zero extended loads
////////////////////////////////////////
`default_nettype none

module rv_data_mem #(
	parameter int DMEM_WORDS = 256
) (
	input logic clk,
	input logic write,
	input rv_pkg::funct3_t funct3,
	input rv_pkg::xlen_t addr,
	input rv_pkg::xlen_t wdata,
	output rv_pkg::xlen_t rdata
);

	localparam int IDX_W = $clog2(DMEM_WORDS);

	rv_pkg::xlen_t mem [DMEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [4:0] lane_sh; // bit offset of addressed byte
	rv_pkg::xlen_t word;
	rv_pkg::xlen_t lane;

	assign idx = addr[IDX_W+1:2]; // word address wraps at depth (power of two)
	assign lane_sh = {addr[1:0], 3'b000};
	assign word = mem[idx];
	assign lane = word >> lane_sh; // addressed lane down to bit 0

	// merge into the stored word, other lanes untouched
	always_ff @(posedge clk) begin
		if (write) begin
			case (funct3)
				rv_pkg::F3_B: mem[idx][lane_sh +: 8] <= wdata[7:0];
				rv_pkg::F3_H: mem[idx][{addr[1], 4'b0000} +: 16] <= wdata[15:0];
				default: mem[idx] <= wdata; // sw
			endcase
		end
	end

	always_comb begin
		case (funct3)
			rv_pkg::F3_B: rdata = {{24{lane[7]}}, lane[7:0]};
			rv_pkg::F3_H: rdata = {{16{lane[15]}}, lane[15:0]};
			rv_pkg::F3_BU: rdata = {24'b0, lane[7:0]};
			rv_pkg::F3_HU: rdata = {16'b0, lane[15:0]};
			rv_pkg::F3_W: rdata = word;
			default: rdata = word;
		endcase
	end

endmodule : rv_data_mem

`default_nettype wire

/* logic/rv_core_top.sv */
////////////////////////////////////////
// single-cycle rv32i core top level
////////////////////////////////////////
`default_nettype none

module rv_core_top #(
	parameter int DMEM_WORDS = 256 // data memory depth in words
) (
	input logic clk,
	input logic reset,
	input rv_pkg::xlen_t instr, // fetched for current pc
	output rv_pkg::xlen_t pc,
	output rv_pkg::retire_t retire
);

	rv_pkg::ctrl_t ctrl;
	rv_pkg::xlen_t mem_addr;
	rv_pkg::xlen_t mem_wdata;
	rv_pkg::funct3_t mem_funct3;
	rv_pkg::xlen_t mem_rdata;

	rv_control control_i (
		.instr(instr),
		.ctrl(ctrl)
	);

	rv_datapath datapath_i (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.ctrl(ctrl),
		.pc(pc),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_funct3(mem_funct3),
		.mem_rdata(mem_rdata),
		.retire(retire)
	);

	rv_data_mem #(
		.DMEM_WORDS(DMEM_WORDS)
	) data_mem_i (
		.clk(clk),
		.write(ctrl.mem_write),
		.funct3(mem_funct3),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule : rv_core_top

`default_nettype wire

/* verif/rv_core_tb.sv */
////////////////////////////////////////
// testbench for the single-cycle core
// program table, random add/xor, checks
////////////////////////////////////////
`default_nettype none

module rv_core_tb;

	localparam int RESET_CYCLES = 4;
	localparam int RAND_PAIRS = 8; // six rows each
	localparam int MARGIN = 20;

	// rv32i major opcodes, from the isa manual
	localparam logic [6:0] LUI = 7'b0110111;
	localparam logic [6:0] AUIPC = 7'b0010111;
	localparam logic [6:0] JALR = 7'b1100111;
	localparam logic [6:0] LOAD = 7'b0000011;
	localparam logic [6:0] IMM = 7'b0010011;

	typedef struct packed {
		logic [31:0] pc; // expected pc while the row executes
		logic [31:0] instr;
		logic valid;
		logic [4:0] rd;
		logic [31:0] data;
	} row_t;

	logic clk;
	logic reset;
	rv_pkg::xlen_t instr;
	rv_pkg::xlen_t pc;
	rv_pkg::retire_t retire;

	row_t rows[$];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 0; // set once the table is built
	integer seed = 84568;

	rv_core_top #(
		.DMEM_WORDS(256)
	) rv_core_top_i (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.pc(pc),
		.retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// instruction word builders
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		r_type = {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		i_type = {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] imm);
		s_type = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		b_type = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
		u_type = {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
		j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic add_row(input logic [31:0] at, input logic [31:0] ins,
		input logic valid, input logic [4:0] rd, input logic [31:0] data);
		row_t r;
		r.pc = at;
		r.instr = ins;
		r.valid = valid;
		r.rd = rd;
		r.data = data;
		rows.push_back(r);
	endtask

	// lui + addi pair, upper part corrected for the signed low 12 bits
	task automatic load_operand(input logic [31:0] at, input logic [4:0] rd,
		input logic [31:0] v);
		logic [31:0] lo;
		logic [31:0] hi;
		lo = {{20{v[11]}}, v[11:0]};
		hi = v - lo;
		add_row(at, u_type(LUI, rd, hi[31:12]), 1'b1, rd, hi);
		add_row(at + 32'd4, i_type(IMM, 3'h0, rd, rd, v[11:0]), 1'b1, rd, v);
	endtask

	task automatic build_program;
		// arithmetic, x1=0x123 x2=-8 x3=5
		add_row(32'h00, i_type(IMM, 3'h0, 5'd1, 5'd0, 12'h123), 1'b1, 5'd1, 32'h00000123);
		add_row(32'h04, i_type(IMM, 3'h0, 5'd2, 5'd0, 12'hFF8), 1'b1, 5'd2, 32'hFFFFFFF8);
		add_row(32'h08, i_type(IMM, 3'h0, 5'd3, 5'd0, 12'h005), 1'b1, 5'd3, 32'h00000005);
		add_row(32'h0C, r_type(7'h00, 3'h0, 5'd4, 5'd1, 5'd3), 1'b1, 5'd4, 32'h00000128);
		add_row(32'h10, r_type(7'h20, 3'h0, 5'd5, 5'd3, 5'd1), 1'b1, 5'd5, 32'hFFFFFEE2);
		add_row(32'h14, r_type(7'h00, 3'h1, 5'd6, 5'd1, 5'd3), 1'b1, 5'd6, 32'h00002460);
		add_row(32'h18, r_type(7'h00, 3'h2, 5'd7, 5'd2, 5'd3), 1'b1, 5'd7, 32'h00000001);
		add_row(32'h1C, r_type(7'h00, 3'h3, 5'd8, 5'd2, 5'd3), 1'b1, 5'd8, 32'h00000000);
		add_row(32'h20, r_type(7'h00, 3'h4, 5'd9, 5'd1, 5'd2), 1'b1, 5'd9, 32'hFFFFFEDB);
		add_row(32'h24, r_type(7'h00, 3'h5, 5'd10, 5'd2, 5'd3), 1'b1, 5'd10, 32'h07FFFFFF);
		add_row(32'h28, r_type(7'h20, 3'h5, 5'd11, 5'd2, 5'd3), 1'b1, 5'd11, 32'hFFFFFFFF);
		add_row(32'h2C, r_type(7'h00, 3'h6, 5'd12, 5'd1, 5'd3), 1'b1, 5'd12, 32'h00000127);
		add_row(32'h30, r_type(7'h00, 3'h7, 5'd13, 5'd1, 5'd2), 1'b1, 5'd13, 32'h00000120);
		add_row(32'h34, i_type(IMM, 3'h2, 5'd14, 5'd2, 12'h001), 1'b1, 5'd14, 32'h00000001);
		add_row(32'h38, i_type(IMM, 3'h3, 5'd15, 5'd2, 12'h001), 1'b1, 5'd15, 32'h00000000);
		add_row(32'h3C, i_type(IMM, 3'h4, 5'd16, 5'd1, 12'hFFF), 1'b1, 5'd16, 32'hFFFFFEDC);
		add_row(32'h40, i_type(IMM, 3'h6, 5'd17, 5'd1, 12'h0F0), 1'b1, 5'd17, 32'h000001F3);
		add_row(32'h44, i_type(IMM, 3'h7, 5'd18, 5'd1, 12'h0F0), 1'b1, 5'd18, 32'h00000020);
		add_row(32'h48, i_type(IMM, 3'h1, 5'd19, 5'd3, 12'h004), 1'b1, 5'd19, 32'h00000050);
		add_row(32'h4C, i_type(IMM, 3'h5, 5'd20, 5'd2, 12'h004), 1'b1, 5'd20, 32'h0FFFFFFF);
		add_row(32'h50, i_type(IMM, 3'h5, 5'd21, 5'd2, 12'h402), 1'b1, 5'd21, 32'hFFFFFFFE);
		add_row(32'h54, i_type(IMM, 3'h0, 5'd0, 5'd1, 12'h007), 1'b1, 5'd0, 32'h0000012A);
		add_row(32'h58, r_type(7'h00, 3'h0, 5'd22, 5'd1, 5'd0), 1'b1, 5'd22, 32'h00000123);
		// upper immediates and jumps, 0x68 is jumped over
		add_row(32'h5C, u_type(LUI, 5'd23, 20'hABCDE), 1'b1, 5'd23, 32'hABCDE000);
		add_row(32'h60, u_type(AUIPC, 5'd24, 20'h00001), 1'b1, 5'd24, 32'h00001060);
		add_row(32'h64, j_type(5'd25, 21'd8), 1'b1, 5'd25, 32'h00000068);
		add_row(32'h6C, i_type(IMM, 3'h0, 5'd26, 5'd0, 12'h081), 1'b1, 5'd26, 32'h00000081);
		add_row(32'h70, i_type(JALR, 3'h0, 5'd27, 5'd26, 12'h000), 1'b1, 5'd27, 32'h00000074);
		// branches, taken skips one word
		add_row(32'h80, b_type(3'h0, 5'd1, 5'd1, 13'd8), 1'b0, 5'd0, 32'h0);
		add_row(32'h88, b_type(3'h0, 5'd1, 5'd3, 13'd8), 1'b0, 5'd0, 32'h0);
		add_row(32'h8C, b_type(3'h1, 5'd1, 5'd3, 13'd8), 1'b0, 5'd0, 32'h0);
		add_row(32'h94, b_type(3'h1, 5'd1, 5'd1, 13'd8), 1'b0, 5'd0, 32'h0);
		add_row(32'h98, b_type(3'h4, 5'd2, 5'd3, 13'd8), 1'b0, 5'd0, 32'h0);
		add_row(32'hA0, b_type(3'h4, 5'd3, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0);
		add_row(32'hA4, b_type(3'h5, 5'd3, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0);
		add_row(32'hAC, b_type(3'h5, 5'd2, 5'd3, 13'd8), 1'b0, 5'd0, 32'h0);
		add_row(32'hB0, b_type(3'h6, 5'd3, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0);
		add_row(32'hB8, b_type(3'h6, 5'd2, 5'd3, 13'd8), 1'b0, 5'd0, 32'h0);
		add_row(32'hBC, b_type(3'h7, 5'd2, 5'd3, 13'd8), 1'b0, 5'd0, 32'h0);
		add_row(32'hC4, b_type(3'h7, 5'd3, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0);
		// memory, one word at 0x100 built from sw, sh, sb
		add_row(32'hC8, i_type(IMM, 3'h0, 5'd28, 5'd0, 12'h100), 1'b1, 5'd28, 32'h00000100);
		add_row(32'hCC, u_type(LUI, 5'd29, 20'h12345), 1'b1, 5'd29, 32'h12345000);
		add_row(32'hD0, i_type(IMM, 3'h0, 5'd29, 5'd29, 12'h678), 1'b1, 5'd29, 32'h12345678);
		add_row(32'hD4, s_type(3'h2, 5'd28, 5'd29, 12'h000), 1'b0, 5'd0, 32'h0);
		add_row(32'hD8, s_type(3'h1, 5'd28, 5'd2, 12'h002), 1'b0, 5'd0, 32'h0);
		add_row(32'hDC, s_type(3'h0, 5'd28, 5'd16, 12'h001), 1'b0, 5'd0, 32'h0);
		add_row(32'hE0, i_type(LOAD, 3'h2, 5'd30, 5'd28, 12'h000), 1'b1, 5'd30, 32'hFFF8DC78);
		add_row(32'hE4, i_type(LOAD, 3'h1, 5'd31, 5'd28, 12'h002), 1'b1, 5'd31, 32'hFFFFFFF8);
		add_row(32'hE8, i_type(LOAD, 3'h5, 5'd31, 5'd28, 12'h002), 1'b1, 5'd31, 32'h0000FFF8);
		add_row(32'hEC, i_type(LOAD, 3'h0, 5'd30, 5'd28, 12'h001), 1'b1, 5'd30, 32'hFFFFFFDC);
		add_row(32'hF0, i_type(LOAD, 3'h4, 5'd30, 5'd28, 12'h001), 1'b1, 5'd30, 32'h000000DC);
		add_row(32'hF4, i_type(LOAD, 3'h1, 5'd29, 5'd28, 12'h000), 1'b1, 5'd29, 32'hFFFFDC78);
		add_row(32'hF8, i_type(LOAD, 3'h0, 5'd29, 5'd28, 12'h003), 1'b1, 5'd29, 32'hFFFFFFFF);
	endtask

	// random operands into x5/x6, add to x7, xor to x8
	task automatic append_random(input logic [31:0] start);
		logic [31:0] p;
		logic [31:0] a;
		logic [31:0] b;
		p = start;
		for (int k = 0; k < RAND_PAIRS; k++) begin
			a = $random(seed);
			b = $random(seed);
			load_operand(p, 5'd5, a);
			load_operand(p + 32'd8, 5'd6, b);
			add_row(p + 32'd16, r_type(7'h00, 3'h0, 5'd7, 5'd5, 5'd6), 1'b1, 5'd7, a + b);
			add_row(p + 32'd20, r_type(7'h00, 3'h4, 5'd8, 5'd5, 5'd6), 1'b1, 5'd8, a ^ b);
			p = p + 32'd24;
		end
	endtask

	task automatic check_reset;
		checks++;
		assert (pc === 32'h0) else begin
			$display("[ERROR] pc in reset expected %h got %h", 32'h0, pc);
			errors++;
		end
		assert (retire.valid === 1'b0) else begin
			$display("[ERROR] retire.valid in reset expected %h got %h", 1'b0, retire.valid);
			errors++;
		end
	endtask

	task automatic check_row(input int idx, input row_t r);
		checks++;
		assert (pc === r.pc) else begin
			$display("[ERROR] pc row %0d expected %h got %h", idx, r.pc, pc);
			errors++;
		end
		assert (retire.valid === r.valid) else begin
			$display("[ERROR] retire.valid row %0d expected %h got %h", idx, r.valid,
				retire.valid);
			errors++;
		end
		if (r.valid) begin // rd and data only mean something on a write
			assert (retire.rd === r.rd) else begin
				$display("[ERROR] retire.rd row %0d expected %h got %h", idx, r.rd, retire.rd);
				errors++;
			end
			assert (retire.data === r.data) else begin
				$display("[ERROR] retire.data row %0d expected %h got %h", idx, r.data,
					retire.data);
				errors++;
			end
		end
	endtask

	// watchdog on the clock
	initial begin
		while (!(limit != 0 && cycles >= limit)) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: program did not finish within %0d cycles", limit);
		errors++;
		$display("errors: %0d, checks: %0d", errors, checks);
		$display("sim failed");
		$finish;
	end

	initial begin
		reset = 1'b0;
		instr = 32'h00000013; // addi x0,x0,0 while in reset
		build_program();
		append_random(32'h000000FC);
		limit = rows.size() + RESET_CYCLES + MARGIN;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			@(negedge clk);
			check_reset();
		end
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			instr <= rows[i].instr; // row executes until the next edge
			if (i == 0) begin
				reset <= 1'b1;
			end
			@(negedge clk); // outputs settled
			check_row(i, rows[i]);
		end
		@(posedge clk);
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule : rv_core_tb

`default_nettype wire

/* src.f */
logic/rv_pkg.sv
logic/rv_alu.sv
logic/rv_imm_decode.sv
logic/rv_regfile.sv
logic/rv_control.sv
logic/rv_datapath.sv
logic/rv_data_mem.sv
logic/rv_core_top.sv
verif/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f src.f --top-module rv_core_tb -o rv_core_sim
./obj_dir/rv_core_sim | tee sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
if ! grep -q "sim passed" sim.log; then
	exit 1
fi
